// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= rv_core_tb
FILELIST  ?= list.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

// File: bench/core_trace.txt
// Hex words: program count, program words, store count, then address and data pairs
// Registers: x1 = -5 and x2 = 7 feed every ALU case below
31
FFB00093 00700113                    // addi x1,x0,-5  addi x2,x0,7
123450B7 00002103 00000463           // lui x1, lw x2, beq must all be no-ops
10102023                             // sw x1 to 0x100
FFC0A193 00513213 0F00C293 55016313  // slti sltiu xori ori
03C0F393 00411413 0080D493 4010D513  // andi slli srli srai
10302223 10402423 10502623 10602823  // sw x3 to x6, 0x104 to 0x110
10702A23 10802C23 10902E23 12A02023  // sw x7 to x10, 0x114 to 0x120
002085B3 40110633 002116B3 0020A733  // add sub sll slt
0020B7B3 0020C833 0020D8B3 4020D933  // sltu xor srl sra
0020E9B3 0020FA33                    // or and
12B02223 12C02423 12D02623 12E02823  // sw x11 to x14, 0x124 to 0x130
12F02A23 13002C23 13102E23 15202023  // sw x15 to x18, 0x134 to 0x140
15302223 15402423                    // sw x19 x20, 0x144 0x148
00110A93 003A8B13 15602623           // x21 = x2+1, x22 = x21+3, sw x22 to 0x14C
06310013 14002823                    // addi x0,x2,99 then sw x0 to 0x150
30000B93 FE2BAC23                    // x23 = 0x300, sw x2 to -8(x23)
16
00000100 FFFFFFFB  00000104 00000001
00000108 00000000  0000010C FFFFFF0B
00000110 00000557  00000114 00000038
00000118 00000070  0000011C 00FFFFFF
00000120 FFFFFFFD  00000124 00000002
00000128 0000000C  0000012C 00000380
00000130 00000001  00000134 00000000
00000138 FFFFFFFC  0000013C 01FFFFFF
00000140 FFFFFFFF  00000144 FFFFFFFF
00000148 00000003  0000014C 0000000B
00000150 00000000  000002F8 00000007

// File: bench/rv_core_tb.sv
`default_nettype none

module rv_core_tb;

    localparam int trace_aw     = 8;
    localparam int trace_depth  = 1 << trace_aw;  // Words in the trace image
    localparam int reset_cycles = 10;
    localparam int store_limit  = 100;  // Cycles allowed from one store to the next
    localparam int quiet_cycles = 20;   // Window for stray stores at the end
    localparam rv_pkg::word_t nop_insn = 32'h0000_0013;  // addi x0, x0, 0

    logic          clk;
    logic          rst_n;
    rv_pkg::word_t imem_addr;
    rv_pkg::word_t imem_insn;
    rv_pkg::word_t dmem_addr;
    rv_pkg::word_t dmem_wdata;
    logic          dmem_wen;

    rv_pkg::word_t trace [0:trace_depth-1];  // Raw trace file image
    int            prog_len;                 // Program sits at trace[1..prog_len]
    int            store_count;
    int            store_base;               // First address/data pair
    rv_pkg::word_t last_fetch;               // Fetch address at the previous falling edge

    ////////////////////////////////////////////////////////////////////////////
    // DUT and clock
    ////////////////////////////////////////////////////////////////////////////

    rv_core DUT (
        .clk, .rst_n,
        .imem_addr, .imem_insn,
        .dmem_addr, .dmem_wdata, .dmem_wen
    );

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;  // Period 10
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Instruction memory
    ////////////////////////////////////////////////////////////////////////////

    function automatic rv_pkg::word_t trace_word(input int pos);
        return trace[pos[trace_aw-1:0]];
    endfunction

    // Word addressed, NOP past the end of the program
    function automatic rv_pkg::word_t imem_word(input rv_pkg::word_t addr);
        int idx;
        idx = int'(addr >> 2);
        if (idx < prog_len) begin
            return trace_word(1 + idx);
        end else begin
            return nop_insn;
        end
    endfunction

    // PC sits at zero in reset, then steps one word or holds on a stall
    always @(negedge clk) begin
        if (!rst_n) begin
            check_word("fetch address in reset", 32'd0, imem_addr);
        end else if (imem_addr !== last_fetch) begin
            check_word("fetch address step", last_fetch + 32'd4, imem_addr);
        end
        last_fetch = imem_addr;
        imem_insn <= imem_word(imem_addr);  // Settled long before the fetch edge
    end

    ////////////////////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////////////////////

    task automatic stop_on_error();
        $display("Simulation failed");
        $fatal(1, "Stopped at the first error, time %0t", $time);
    endtask

    task automatic check_word(input string name, input rv_pkg::word_t expected,
                              input rv_pkg::word_t actual);
        if (actual !== expected) begin
            $display("FAILED %s: expected %h, actual %h", name, expected, actual);
            stop_on_error();
        end
    endtask

    // Advances at least one cycle, so back-to-back stores are seen apart
    task automatic wait_for_store(input int num);
        int cycles;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
            if (cycles > store_limit) begin
                $display("Store %0d never arrived within %0d cycles", num, store_limit);
                stop_on_error();
            end
        end while (!dmem_wen);
    endtask

    task automatic expect_no_store(input int cycles, input string phase);
        for (int i = 0; i < cycles; i++) begin
            @(negedge clk);
            if (dmem_wen) begin
                $display("Unexpected store to %h during %s", dmem_addr, phase);
                stop_on_error();
            end
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        rst_n     = 1'b0;
        imem_insn = nop_insn;

        $readmemh("bench/core_trace.txt", trace);
        prog_len = int'(trace_word(0));
        if (prog_len < 1 || prog_len + 2 > trace_depth) begin
            $display("Trace file is missing or its program count is bad");
            stop_on_error();
        end
        store_count = int'(trace_word(prog_len + 1));
        store_base  = prog_len + 2;
        if (store_count < 1 || store_base + 2 * store_count > trace_depth) begin
            $display("Trace file store count is bad");
            stop_on_error();
        end

        expect_no_store(reset_cycles, "reset");  // Data port idle in reset
        rst_n = 1'b1;

        // Stores arrive in program order, latency varies with stalls
        for (int i = 0; i < store_count; i++) begin
            wait_for_store(i);
            check_word($sformatf("store %0d address", i),
                       trace_word(store_base + 2 * i), dmem_addr);
            check_word($sformatf("store %0d data", i),
                       trace_word(store_base + 2 * i + 1), dmem_wdata);
        end

        expect_no_store(quiet_cycles, "the window after the last store");
        $display("Simulation passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: list.f
logic/rv_pkg.sv
logic/fetch_pc.sv
logic/hazard_ctrl.sv
logic/decode_unit.sv
logic/reg_file.sv
logic/alu.sv
logic/stage_reg.sv
logic/rv_core.sv
bench/rv_core_tb.sv

// File: logic/alu.sv
`default_nettype none

module alu (
    input  rv_pkg::alu_op_t op,
    input  rv_pkg::word_t   a,        // rs1 value
    input  rv_pkg::word_t   b,        // rs2 value
    input  rv_pkg::word_t   imm,
    input  logic            use_imm,  // I-type and store address
    output rv_pkg::word_t   result
);

    rv_pkg::word_t opb;
    logic [4:0]    shamt;

    assign opb   = use_imm ? imm : b;
    assign shamt = opb[4:0];  // Upper bits ignored for shifts

    always_comb begin
        case (op)
            rv_pkg::alu_add:  result = a + opb;
            rv_pkg::alu_sub:  result = a - opb;
            rv_pkg::alu_sll:  result = a << shamt;
            rv_pkg::alu_srl:  result = a >> shamt;
            rv_pkg::alu_sra:  result = $signed(a) >>> shamt;  // Sign fills from bit 31
            rv_pkg::alu_xor:  result = a ^ opb;
            rv_pkg::alu_or:   result = a | opb;
            rv_pkg::alu_and:  result = a & opb;
            rv_pkg::alu_slt: begin
                // Signed compare
                result = {{(rv_pkg::xlen-1){1'b0}}, $signed(a) < $signed(opb)};
            end
            rv_pkg::alu_sltu: begin
                // Unsigned compare, SLTIU still sign-extends the immediate
                result = {{(rv_pkg::xlen-1){1'b0}}, a < opb};
            end
            default: result = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: logic/decode_unit.sv
`default_nettype none

module decode_unit (
    input  rv_pkg::word_t    insn,
    input  rv_pkg::word_t    insn_pc,
    output rv_pkg::reg_idx_t rs1,      // Register file read addresses
    output rv_pkg::reg_idx_t rs2,
    output logic             use_rs1,  // To the interlock
    output logic             use_rs2,
    input  rv_pkg::word_t    rd1,      // Register file read data
    input  rv_pkg::word_t    rd2,
    output rv_pkg::id_ex_t   id_ex
);

    logic [6:0]    opcode;
    logic [2:0]    funct3;
    logic          bit30;  // funct7[5], SUB and SRA select
    rv_pkg::word_t imm_i;
    rv_pkg::word_t imm_s;

    // funct3 to ALU operation, shared by I and R forms
    function automatic rv_pkg::alu_op_t alu_sel(
        input logic [2:0] f3,
        input logic       b30,
        input logic       is_rtype
    );
        rv_pkg::alu_op_t op;
        case (f3)
            3'b000: begin
                if (is_rtype && b30) begin
                    op = rv_pkg::alu_sub;  // ADDI ignores bit 30
                end else begin
                    op = rv_pkg::alu_add;
                end
            end
            3'b001: op = rv_pkg::alu_sll;
            3'b010: op = rv_pkg::alu_slt;
            3'b011: op = rv_pkg::alu_sltu;
            3'b100: op = rv_pkg::alu_xor;
            3'b101: begin
                if (b30) begin
                    op = rv_pkg::alu_sra;  // SRA and SRAI
                end else begin
                    op = rv_pkg::alu_srl;
                end
            end
            3'b110: op = rv_pkg::alu_or;
            default: op = rv_pkg::alu_and;
        endcase
        return op;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Field extraction
    ////////////////////////////////////////////////////////////////////////////

    assign opcode = insn[6:0];
    assign funct3 = insn[14:12];
    assign bit30  = insn[30];
    assign rs1    = insn[19:15];
    assign rs2    = insn[24:20];

    // Sign-extended immediates
    assign imm_i = {{(rv_pkg::xlen-12){insn[31]}}, insn[31:20]};
    assign imm_s = {{(rv_pkg::xlen-12){insn[31]}}, insn[31:25], insn[11:7]};

    ////////////////////////////////////////////////////////////////////////////
    // Control
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        use_rs1 = 1'b0;
        use_rs2 = 1'b0;

        id_ex      = '0;  // No-op unless a kept opcode
        id_ex.pc   = insn_pc;
        id_ex.op_a = rd1;
        id_ex.op_b = rd2;

        case (opcode)
            rv_pkg::opc_itype: begin
                use_rs1        = 1'b1;
                id_ex.imm      = imm_i;
                id_ex.use_imm  = 1'b1;
                id_ex.alu_op   = alu_sel(funct3, bit30, 1'b0);
                id_ex.reg_wr   = 1'b1;
                id_ex.rd       = insn[11:7];
            end
            rv_pkg::opc_rtype: begin
                use_rs1        = 1'b1;
                use_rs2        = 1'b1;
                id_ex.alu_op   = alu_sel(funct3, bit30, 1'b1);
                id_ex.reg_wr   = 1'b1;
                id_ex.rd       = insn[11:7];
            end
            rv_pkg::opc_stype: begin
                use_rs1        = 1'b1;  // Base address
                use_rs2        = 1'b1;  // Store data
                id_ex.imm      = imm_s;
                id_ex.use_imm  = 1'b1;
                id_ex.alu_op   = rv_pkg::alu_add;  // Address sum
                id_ex.store    = 1'b1;
            end
            default: begin
                // Loads, branches, jumps, LUI fall through as bubbles
            end
        endcase
    end

endmodule

`default_nettype wire

// File: logic/fetch_pc.sv
`default_nettype none

module fetch_pc (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          stall,      // Hold PC and fetch/decode register
    output rv_pkg::word_t imem_addr,
    input  rv_pkg::word_t imem_insn,  // Combinational answer from imem
    output rv_pkg::word_t insn,
    output rv_pkg::word_t insn_pc
);

    rv_pkg::word_t pc;

    assign imem_addr = pc;  // Fetch straight from the PC

    // PC and fetch/decode register move together
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc      <= '0;
            insn    <= '0;  // Opcode zero decodes as a no-op
            insn_pc <= '0;
        end else if (!stall) begin
            pc      <= pc + rv_pkg::pc_step;
            insn    <= imem_insn;
            insn_pc <= pc;
        end
    end

    // No jumps, so the PC only walks in word steps
    pc_aligned: assert property (
        @(posedge clk) disable iff (!rst_n)
        pc[1:0] == 2'b00
    ) else $error("PC not word aligned: %h", pc);

endmodule

`default_nettype wire

// File: logic/hazard_ctrl.sv
`default_nettype none

module hazard_ctrl (
    input  rv_pkg::reg_idx_t rs1,
    input  rv_pkg::reg_idx_t rs2,
    input  logic             use_rs1,  // Source fields actually read
    input  logic             use_rs2,
    input  rv_pkg::reg_idx_t ex_rd,    // Destination in execute
    input  rv_pkg::reg_idx_t mem_rd,   // Destination in memory
    input  logic             ex_wr,
    input  logic             mem_wr,
    output logic             stall
);

    logic ex_hit;   // Decode needs the result in execute
    logic mem_hit;  // Decode needs the result in memory

    // No forwarding, decode waits until the producer is in writeback
    always_comb begin
        ex_hit  = ex_wr && (ex_rd != '0)
                  && ((use_rs1 && rs1 == ex_rd) || (use_rs2 && rs2 == ex_rd));
        mem_hit = mem_wr && (mem_rd != '0)
                  && ((use_rs1 && rs1 == mem_rd) || (use_rs2 && rs2 == mem_rd));
        stall   = ex_hit || mem_hit;

        // Bubbles and stores travel with rd = x0
        assert ((ex_wr || ex_rd == '0) && (mem_wr || mem_rd == '0))
            else $error("Pending slot without a write carries a nonzero destination");
    end

endmodule

`default_nettype wire

// File: logic/reg_file.sv
`default_nettype none

module reg_file (
    input  logic             clk,
    input  logic             rst_n,
    input  rv_pkg::reg_idx_t raddr1,
    input  rv_pkg::reg_idx_t raddr2,
    output rv_pkg::word_t    rdata1,
    output rv_pkg::word_t    rdata2,
    input  logic             we,     // From writeback
    input  rv_pkg::reg_idx_t waddr,
    input  rv_pkg::word_t    wdata
);

    rv_pkg::word_t regs [0:(1 << rv_pkg::reg_addr_w)-1];  // Entry 0 never written

    always_ff @(posedge clk) begin
        if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    // Read side, x0 first, then same-cycle bypass
    always_comb begin
        if (raddr1 == '0) begin
            rdata1 = '0;
        end else if (we && waddr == raddr1) begin
            rdata1 = wdata;  // Writeback lands this edge
        end else begin
            rdata1 = regs[raddr1];
        end

        if (raddr2 == '0) begin
            rdata2 = '0;
        end else if (we && waddr == raddr2) begin
            rdata2 = wdata;
        end else begin
            rdata2 = regs[raddr2];
        end
    end

    x0_reads_zero: assert property (
        @(posedge clk) disable iff (!rst_n)
        (raddr1 == '0 |-> rdata1 == '0) and (raddr2 == '0 |-> rdata2 == '0)
    ) else $error("x0 read back nonzero");

endmodule

`default_nettype wire

// File: logic/rv_core.sv
`default_nettype none

module rv_core (
    input  logic          clk,
    input  logic          rst_n,
    output rv_pkg::word_t imem_addr,
    input  rv_pkg::word_t imem_insn,
    output rv_pkg::word_t dmem_addr,
    output rv_pkg::word_t dmem_wdata,
    output logic          dmem_wen
);

    rv_pkg::word_t    insn;
    rv_pkg::word_t    insn_pc;
    logic             stall;
    rv_pkg::reg_idx_t rs1;
    rv_pkg::reg_idx_t rs2;
    logic             use_rs1;
    logic             use_rs2;
    rv_pkg::word_t    rd1;
    rv_pkg::word_t    rd2;
    rv_pkg::word_t    alu_result;

    rv_pkg::id_ex_t  id_ex_d,  id_ex_q;
    rv_pkg::ex_mem_t ex_mem_d, ex_mem_q;
    rv_pkg::mem_wb_t mem_wb_d, mem_wb_q;

    ////////////////////////////////////////////////////////////////////////////
    // Fetch and decode
    ////////////////////////////////////////////////////////////////////////////

    fetch_pc u_fetch (
        .clk, .rst_n, .stall,
        .imem_addr, .imem_insn,
        .insn, .insn_pc
    );

    hazard_ctrl u_hazard (
        .rs1, .rs2, .use_rs1, .use_rs2,
        .ex_rd  (id_ex_q.rd),  .ex_wr  (id_ex_q.reg_wr),
        .mem_rd (ex_mem_q.rd), .mem_wr (ex_mem_q.reg_wr),
        .stall
    );

    decode_unit u_decode (
        .insn, .insn_pc, .rs1, .rs2, .use_rs1, .use_rs2,
        .rd1, .rd2, .id_ex (id_ex_d)
    );

    reg_file u_regs (
        .clk, .rst_n,
        .raddr1 (rs1), .raddr2 (rs2), .rdata1 (rd1), .rdata2 (rd2),
        .we     (mem_wb_q.reg_wr),  // Writeback port
        .waddr  (mem_wb_q.rd),
        .wdata  (mem_wb_q.result)
    );

    // Stall holds decode and sends a bubble into execute
    stage_reg #(.payload_t(rv_pkg::id_ex_t)) u_id_ex (
        .clk, .rst_n, .en (!stall), .bubble (stall), .d (id_ex_d), .q (id_ex_q)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Execute, memory, writeback
    ////////////////////////////////////////////////////////////////////////////

    alu u_alu (
        .op (id_ex_q.alu_op), .a (id_ex_q.op_a), .b (id_ex_q.op_b),
        .imm (id_ex_q.imm), .use_imm (id_ex_q.use_imm), .result (alu_result)
    );

    assign ex_mem_d = '{result: alu_result, wdata: id_ex_q.op_b, reg_wr: id_ex_q.reg_wr,
                        store: id_ex_q.store, rd: id_ex_q.rd};

    stage_reg #(.payload_t(rv_pkg::ex_mem_t)) u_ex_mem (
        .clk, .rst_n, .en (1'b1), .bubble (1'b0), .d (ex_mem_d), .q (ex_mem_q)
    );

    // Data port straight from the memory stage, no load path
    assign dmem_addr  = ex_mem_q.result;
    assign dmem_wdata = ex_mem_q.wdata;
    assign dmem_wen   = ex_mem_q.store;

    assign mem_wb_d = '{result: ex_mem_q.result, reg_wr: ex_mem_q.reg_wr, rd: ex_mem_q.rd};

    stage_reg #(.payload_t(rv_pkg::mem_wb_t)) u_mem_wb (
        .clk, .rst_n, .en (1'b1), .bubble (1'b0), .d (mem_wb_d), .q (mem_wb_q)
    );

    // Live op in execute is at least two words behind fetch
    ex_behind_fetch: assert property (
        @(posedge clk) disable iff (!rst_n)
        (id_ex_q.reg_wr || id_ex_q.store) |-> imem_addr >= id_ex_q.pc + 2 * rv_pkg::pc_step
    ) else $error("Execute PC %h not behind fetch PC %h", id_ex_q.pc, imem_addr);

endmodule

`default_nettype wire

// File: logic/rv_pkg.sv
`default_nettype none

package rv_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Widths and fixed encodings
    ////////////////////////////////////////////////////////////////////////////

    localparam int xlen       = 32;  // Data and address width
    localparam int reg_addr_w = 5;   // 32 architectural registers

    // Major opcodes kept by this core
    localparam logic [6:0] opc_itype = 7'b0010011;  // OP-IMM
    localparam logic [6:0] opc_rtype = 7'b0110011;  // OP
    localparam logic [6:0] opc_stype = 7'b0100011;  // STORE

    typedef logic [xlen-1:0]       word_t;
    typedef logic [reg_addr_w-1:0] reg_idx_t;

    localparam word_t pc_step = 32'd4;  // No compressed instructions

    // ALU operations, independent of the funct3 encoding
    typedef enum logic [3:0] {
        alu_add  = 4'd0,
        alu_sub  = 4'd1,
        alu_sll  = 4'd2,
        alu_slt  = 4'd3,
        alu_sltu = 4'd4,
        alu_xor  = 4'd5,
        alu_srl  = 4'd6,
        alu_sra  = 4'd7,
        alu_or   = 4'd8,
        alu_and  = 4'd9
    } alu_op_t;

    ////////////////////////////////////////////////////////////////////////////
    // Stage payloads
    ////////////////////////////////////////////////////////////////////////////

    // Decode to execute, 140 bits
    typedef struct packed {
        word_t    pc;       // Address of the instruction
        word_t    op_a;     // rs1 value
        word_t    op_b;     // rs2 value, also store data
        word_t    imm;      // Sign-extended I or S immediate
        alu_op_t  alu_op;
        logic     use_imm;  // Operand B from imm
        logic     reg_wr;   // Writes rd at writeback
        logic     store;    // Drives the data port in memory
        reg_idx_t rd;       // Zero when nothing is written
    } id_ex_t;

    // Execute to memory, 71 bits
    typedef struct packed {
        word_t    result;   // ALU output, store address for S-type
        word_t    wdata;    // Store data
        logic     reg_wr;
        logic     store;
        reg_idx_t rd;
    } ex_mem_t;

    // Memory to writeback, 38 bits
    typedef struct packed {
        word_t    result;
        logic     reg_wr;
        reg_idx_t rd;
    } mem_wb_t;

endpackage

`default_nettype wire

// File: logic/stage_reg.sv
`default_nettype none

module stage_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     en,      // Load d
    input  logic     bubble,  // Load an all-zero payload
    input  payload_t d,
    output payload_t q
);

    // Zero payload has write and store cleared and rd = x0
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            q <= '0;
        end else if (bubble) begin
            q <= '0;  // Held instruction stays upstream
        end else if (en) begin
            q <= d;
        end
    end

endmodule

`default_nettype wire
